//--- hw/fir_defines.svh
// fir decimator parameters
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// sample and coefficient width in bits
`define DATA_WIDTH 16

// filter length
`define NUM_TAPS 16

// input samples consumed per output sample
`define DECIMATION 4

// coefficients are fixed point with this many fraction bits
`define COEF_FRAC_BITS 10

// divisor applied to every tap product
`define COEF_SCALE (1 << `COEF_FRAC_BITS)

// entries in each stream fifo
`define FIFO_DEPTH 8

`endif

//--- hw/sample_pkg.sv
// sample and coefficient types
`include "fir_defines.svh"

package sample_pkg;

    // signed sample, also the accumulator since the sum wraps
    typedef logic signed [`DATA_WIDTH-1:0] sample_t;

    // signed coefficient, COEF_FRAC_BITS fraction bits
    typedef logic signed [`DATA_WIDTH-1:0] coef_t;

    // full precision tap product
    typedef logic signed [2*`DATA_WIDTH-1:0] product_t;

    // symmetric low-pass, peak 300 at the centre pair
    // taps add up to 1024, unity gain at dc
    localparam coef_t fir_coefs [`NUM_TAPS] = '{
        coef_t'(-4),  coef_t'(-6),  coef_t'(2),   coef_t'(16),
        coef_t'(40),  coef_t'(70),  coef_t'(94),  coef_t'(300),
        coef_t'(300), coef_t'(94),  coef_t'(70),  coef_t'(40),
        coef_t'(16),  coef_t'(2),   coef_t'(-6),  coef_t'(-4)
    };

endpackage

//--- hw/fir_ctrl_pkg.sv
// filter control types
`include "fir_defines.svh"

package fir_ctrl_pkg;

    // control fsm states
    // COLLECT    pull samples into the delay line
    // MAC_RUN    one tap selected per cycle
    // MAC_DRAIN  last tap accumulated
    // EMIT       push the sum into the output fifo
    typedef enum logic [1:0] {
        COLLECT,
        MAC_RUN,
        MAC_DRAIN,
        EMIT
    } fir_state_t;

    // selects one of the NUM_TAPS taps
    typedef logic [$clog2(`NUM_TAPS)-1:0] tap_idx_t;

endpackage

//--- hw/mac_bus_if.sv
// control to datapath bus
interface mac_bus_if;
    import sample_pkg::*;
    import fir_ctrl_pkg::*;

    // delay line shift strobe and new sample
    logic     shift_en;
    sample_t  shift_sample;
    // tap select, seen by delay line and mac
    tap_idx_t tap_sel;
    // registered tap value, one cycle after tap_sel
    sample_t  tap_sample;
    // accumulator control and result
    logic     acc_clear;
    logic     acc_en;
    sample_t  acc_sum;

    modport ctrl (output shift_en, shift_sample, tap_sel, acc_clear, acc_en,
                  input acc_sum);

    modport delay (input shift_en, shift_sample, tap_sel,
                   output tap_sample);

    modport mac (input tap_sel, tap_sample, acc_clear, acc_en,
                 output acc_sum);

endinterface

//--- hw/sample_fifo.sv
// first-word-fall-through sample fifo
module sample_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                wr_en,
    input  sample_pkg::sample_t din,
    output logic                full,
    input  logic                rd_en,
    output sample_pkg::sample_t dout,
    output logic                empty
);
    import sample_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

    sample_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic wr_ok;
    logic rd_ok;

    // strobes against a full or empty fifo are dropped
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);
    // head entry shown with no read latency
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                // wrap explicitly, depth need not be a power of two
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

//--- hw/tap_delay_line.sv
// fir tap delay line
`include "fir_defines.svh"

module tap_delay_line (
    input logic      clock,
    input logic      reset,
    mac_bus_if.delay bus
);
    import sample_pkg::*;

    // tap j holds the sample shifted in j shifts ago
    sample_t taps [`NUM_TAPS];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            taps <= '{default: '0};
        end else if (bus.shift_en) begin
            // oldest sample falls off the end
            for (int i = `NUM_TAPS - 1; i > 0; i--) begin
                taps[i] <= taps[i-1];
            end
            taps[0] <= bus.shift_sample;
        end
    end

    // selected tap registered every cycle
    // mac sees it one cycle after tap_sel
    always_ff @(posedge clock) begin
        bus.tap_sample <= taps[bus.tap_sel];
    end

endmodule

//--- hw/fir_mac.sv
// fir multiply-accumulate
`include "fir_defines.svh"

module fir_mac (
    input logic    clock,
    input logic    reset,
    mac_bus_if.mac bus
);
    import sample_pkg::*;
    import fir_ctrl_pkg::*;

    // tap_sel delayed to line up with tap_sample
    tap_idx_t coef_sel;
    product_t product;
    // scaled product, cut to sample width
    sample_t  term;
    sample_t  acc;

    always_ff @(posedge clock) begin
        coef_sel <= bus.tap_sel;
    end

    // full width signed product
    assign product = product_t'(bus.tap_sample) * product_t'(fir_coefs[coef_sel]);
    // signed divide, truncates toward zero
    assign term = sample_t'(product / `COEF_SCALE);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            acc <= '0;
        end else if (bus.acc_clear) begin
            acc <= '0;
        end else if (bus.acc_en) begin
            // wraps at sample width
            acc <= acc + term;
        end
    end

    assign bus.acc_sum = acc;

endmodule

//--- hw/fir_ctrl.sv
// fir decimator control fsm
`include "fir_defines.svh"

module fir_ctrl (
    input  logic                clock,
    input  logic                reset,
    mac_bus_if.ctrl             bus,
    input  logic                in_empty,
    input  sample_pkg::sample_t in_sample,
    output logic                in_rd_en,
    input  logic                out_full,
    output logic                out_wr_en,
    output sample_pkg::sample_t out_sample
);
    import fir_ctrl_pkg::*;

    localparam int DEC_W = $clog2(`DECIMATION);
    localparam logic [DEC_W-1:0] LAST_DEC = DEC_W'(`DECIMATION - 1);
    localparam tap_idx_t LAST_TAP = tap_idx_t'(`NUM_TAPS - 1);

    fir_state_t state;
    fir_state_t next_state;
    logic [DEC_W-1:0] dec_cnt;
    logic [DEC_W-1:0] dec_cnt_c;
    tap_idx_t tap_cnt;
    tap_idx_t tap_cnt_c;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= COLLECT;
            dec_cnt <= '0;
            tap_cnt <= '0;
        end else begin
            state   <= next_state;
            dec_cnt <= dec_cnt_c;
            tap_cnt <= tap_cnt_c;
        end
    end

    // input fifo head goes straight into the delay line
    assign bus.shift_sample = in_sample;
    // tap counter doubles as the tap select
    assign bus.tap_sel = tap_cnt;
    assign out_sample = bus.acc_sum;

    always_comb begin
        next_state    = state;
        dec_cnt_c     = dec_cnt;
        tap_cnt_c     = tap_cnt;
        in_rd_en      = 1'b0;
        out_wr_en     = 1'b0;
        bus.shift_en  = 1'b0;
        bus.acc_clear = 1'b0;
        bus.acc_en    = 1'b0;
        case (state)
            COLLECT: begin
                // one sample per cycle while input is available
                if (!in_empty) begin
                    in_rd_en     = 1'b1;
                    bus.shift_en = 1'b1;
                    if (dec_cnt == LAST_DEC) begin
                        // group complete, start a fresh pass
                        dec_cnt_c     = '0;
                        tap_cnt_c     = '0;
                        bus.acc_clear = 1'b1;
                        next_state    = MAC_RUN;
                    end else begin
                        dec_cnt_c = dec_cnt + 1'b1;
                    end
                end
            end
            MAC_RUN: begin
                // tap 0 not yet registered in the first cycle
                bus.acc_en = (tap_cnt != '0);
                tap_cnt_c  = tap_cnt + 1'b1;
                if (tap_cnt == LAST_TAP) begin
                    next_state = MAC_DRAIN;
                end
            end
            MAC_DRAIN: begin
                // last tap in flight
                bus.acc_en = 1'b1;
                next_state = EMIT;
            end
            EMIT: begin
                // hold here under back-pressure
                if (!out_full) begin
                    out_wr_en  = 1'b1;
                    next_state = COLLECT;
                end
            end
            default: begin
                next_state = COLLECT;
            end
        endcase
    end

endmodule

//--- hw/fir_decimator_top.sv
// decimating fir filter stream
`include "fir_defines.svh"

module fir_decimator_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_wr_en,
    input  logic [`DATA_WIDTH-1:0] in_din,
    output logic                   in_full,
    input  logic                   out_rd_en,
    output logic [`DATA_WIDTH-1:0] out_dout,
    output logic                   out_empty
);
    import sample_pkg::*;

    // input fifo to control
    sample_t in_dout;
    logic    in_empty;
    logic    in_rd_en;
    // control to output fifo
    sample_t out_din;
    logic    out_wr_en;
    logic    out_full;

    mac_bus_if mac_bus ();

    sample_fifo #(
        .DEPTH (`FIFO_DEPTH)
    ) in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (in_rd_en),
        .dout  (in_dout),
        .empty (in_empty)
    );

    fir_ctrl fir_ctrl_i (
        .clock      (clock),
        .reset      (reset),
        .bus        (mac_bus.ctrl),
        .in_empty   (in_empty),
        .in_sample  (in_dout),
        .in_rd_en   (in_rd_en),
        .out_full   (out_full),
        .out_wr_en  (out_wr_en),
        .out_sample (out_din)
    );

    tap_delay_line tap_delay_line_i (
        .clock (clock),
        .reset (reset),
        .bus   (mac_bus.delay)
    );

    fir_mac fir_mac_i (
        .clock (clock),
        .reset (reset),
        .bus   (mac_bus.mac)
    );

    sample_fifo #(
        .DEPTH (`FIFO_DEPTH)
    ) out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (out_wr_en),
        .din   (out_din),
        .full  (out_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

//--- bench/clock_gen.sv
// testbench clock source
module clock_gen (
    output logic clock
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    localparam int HALF_PERIOD = 4;

    initial begin
        clock = 1'b0;
        forever begin
            #HALF_PERIOD clock = ~clock;
        end
    end

endmodule

//--- bench/fir_decimator_tb.sv
// fir decimator testbench
`include "fir_defines.svh"

module fir_decimator_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import sample_pkg::*;
    import fir_ctrl_pkg::*;

    // impulse, constant, random, back-pressure, pre-reset and post-reset samples
    localparam int TOTAL_SAMPLES = 24 + 64 + 200 + 60 + 6 + 40;
    localparam int CYCLE_LIMIT = 40 * TOTAL_SAMPLES + 1000;
    localparam int HOLD_CYCLES = 20;

    logic clock;
    logic reset;
    logic in_wr_en;
    logic [`DATA_WIDTH-1:0] in_din;
    logic in_full;
    logic out_rd_en;
    logic [`DATA_WIDTH-1:0] out_dout;
    logic out_empty;

    // samples accepted since the last reset
    sample_t history [$];
    // samples still to be written
    sample_t pending [$];
    // outputs read back during the current test
    sample_t received [$];
    int out_count;
    int cycle_count = 0;

    clock_gen clock_gen_i (
        .clock (clock)
    );

    fir_decimator_top fir_decimator_top_i (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compare_sample(input sample_t expected, input sample_t actual,
                                  input string what);
        if (actual !== expected) begin
            $display("[ERROR] time %0d ns: %s expected %0d, got %0d",
                     $time, what, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic compare_flag(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            $display("[ERROR] time %0d ns: %s expected %b, got %b",
                     $time, what, expected, actual);
            stop_with_failure();
        end
    endtask

    // output k from the history with zeros before the first sample
    function automatic sample_t model_output(input int k);
        int newest;
        int idx;
        int acc;
        newest = (k + 1) * `DECIMATION - 1;
        acc = 0;
        for (int j = 0; j < `NUM_TAPS; j++) begin
            idx = newest - j;
            if (idx >= 0) begin
                // int divide truncates toward zero
                acc += (int'(history[idx]) * int'(fir_coefs[tap_idx_t'(j)])) / `COEF_SCALE;
            end
        end
        // wrap to sample width
        return sample_t'(acc);
    endfunction

    // one falling edge that checks and pops an output and offers the next sample
    task automatic step_stream(input bit allow_read);
        @(negedge clock);
        in_wr_en  = 1'b0;
        out_rd_en = 1'b0;
        if (allow_read && !out_empty) begin
            if (out_count >= history.size() / `DECIMATION) begin
                $display("output %0d appeared without a complete input group", out_count);
                stop_with_failure();
            end
            compare_sample(model_output(out_count), sample_t'(out_dout), "stream output");
            received.push_back(sample_t'(out_dout));
            out_count++;
            out_rd_en = 1'b1;
        end
        // retried every cycle until in_full drops
        if (pending.size() > 0 && !in_full) begin
            in_din   = pending[0];
            in_wr_en = 1'b1;
            history.push_back(pending.pop_front());
        end
    endtask

    // run until every complete group has been read back
    task automatic drain_stream();
        while (pending.size() > 0 || out_count < history.size() / `DECIMATION) begin
            step_stream(1'b1);
        end
        // quiet window where any stray output fails in step_stream
        repeat (2 * `NUM_TAPS) step_stream(1'b1);
        compare_flag(1'b1, out_empty, "out_empty after drain");
    endtask

    task automatic apply_reset();
        @(negedge clock);
        reset     = 1'b1;
        in_wr_en  = 1'b0;
        out_rd_en = 1'b0;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        // model restarts from an all-zero history
        history.delete();
        pending.delete();
        out_count = 0;
    endtask

    task automatic impulse_test();
        sample_t expected;
        int tap;
        received.delete();
        pending.push_back(sample_t'(1000));
        repeat (23) pending.push_back(sample_t'(0));
        drain_stream();
        for (int k = 0; k < 6; k++) begin
            tap = k * `DECIMATION + `DECIMATION - 1;
            if (tap < `NUM_TAPS) begin
                expected = sample_t'((1000 * int'(fir_coefs[tap_idx_t'(tap)])) / `COEF_SCALE);
            end else begin
                expected = sample_t'(0);
            end
            compare_sample(expected, received[k], "impulse response");
        end
    endtask

    task automatic constant_test();
        int settled;
        received.delete();
        repeat (64) pending.push_back(sample_t'(512));
        drain_stream();
        settled = 0;
        for (int j = 0; j < `NUM_TAPS; j++) begin
            settled += (512 * int'(fir_coefs[tap_idx_t'(j)])) / `COEF_SCALE;
        end
        compare_sample(sample_t'(settled), received[received.size() - 1], "settled dc output");
    endtask

    task automatic random_test();
        received.delete();
        repeat (200) pending.push_back(sample_t'($urandom()));
        drain_stream();
    endtask

    task automatic backpressure_test();
        int offered;
        // more than the output fifo can absorb
        offered = `FIFO_DEPTH * `DECIMATION + 28;
        received.delete();
        repeat (offered) pending.push_back(sample_t'($urandom()));
        while (!in_full) begin
            step_stream(1'b0);
        end
        repeat (HOLD_CYCLES) step_stream(1'b0);
        compare_flag(1'b1, in_full, "in_full under back-pressure");
        drain_stream();
    endtask

    task automatic reset_test();
        received.delete();
        // one full group and half of the next
        repeat (6) pending.push_back(sample_t'($urandom()));
        while (pending.size() > 0) begin
            step_stream(1'b0);
        end
        // reset once the first output sits in the output fifo
        while (out_empty) begin
            step_stream(1'b0);
        end
        apply_reset();
        compare_flag(1'b1, out_empty, "out_empty straight after reset");
        repeat (40) pending.push_back(sample_t'($urandom()));
        drain_stream();
    endtask

    // watchdog
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            stop_with_failure();
        end
    end

    initial begin
        void'($urandom(32'h963c_0d91));
        reset     = 1'b1;
        in_wr_en  = 1'b0;
        in_din    = '0;
        out_rd_en = 1'b0;
        out_count = 0;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        impulse_test();
        constant_test();
        random_test();
        backpressure_test();
        reset_test();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+hw
hw/sample_pkg.sv
hw/fir_ctrl_pkg.sv
hw/mac_bus_if.sv
hw/sample_fifo.sv
hw/tap_delay_line.sv
hw/fir_mac.sv
hw/fir_ctrl.sv
hw/fir_decimator_top.sv
bench/clock_gen.sv
bench/fir_decimator_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= fir_decimator_tb
FLAGS ?= --binary --timing
OBJ_DIR ?= obj_dir

SOURCES := $(shell grep -v '^+' sim.f) hw/fir_defines.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): sim.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

run: $(BIN)
	@out="$$(./$(BIN))"; status=$$?; echo "$$out"; \
	[ $$status -eq 0 ] && echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
